/* forwardUnit.f */
+incdir+include
verilog/pipeTypesPkg.sv
verilog/forwardPkg.sv
verilog/producerSelect.sv
verilog/aluOperandForward.sv
verilog/controlTransferForward.sv
verilog/forwardUnit.sv
dv/forwardUnitTb.sv

/* runSim.sh */
#!/bin/sh
# compile and run the forwarding unit testbench, pass only if the log says so

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module forwardUnitTb -Mdir obj_dir -f forwardUnit.f \
    || { echo "build failed"; exit 1; }

./obj_dir/VforwardUnitTb > sim.log 2>&1
cat sim.log

grep -q "^No errors$" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

/* include/forwardModel.svh */
`ifndef FORWARD_MODEL_SVH
`define FORWARD_MODEL_SVH
`default_nettype none

// producer writes the requested register and that register is not r0
function automatic bit producerMatches(pipeTypesPkg::regIndexT request, logic writeEnable,
                                       pipeTypesPkg::regIndexT dest);
    return writeEnable && (dest == request) && (request != forwardPkg::zeroReg);
endfunction

// newest matching producer in priority order
function automatic forwardPkg::forwardSourceE newestSource(
    pipeTypesPkg::regIndexT request, bit useExecute,
    pipeTypesPkg::producerT executeProd, pipeTypesPkg::loadProducerT exeMemProd,
    pipeTypesPkg::producerT memWbProd, pipeTypesPkg::producerT writebackProd);
    if (useExecute && producerMatches(request, executeProd.writeEnable, executeProd.dest))
        return forwardPkg::srcExecute;
    if (producerMatches(request, exeMemProd.writeEnable, exeMemProd.dest))
        return forwardPkg::srcExeMem;
    if (producerMatches(request, memWbProd.writeEnable, memWbProd.dest))
        return forwardPkg::srcMemWb;
    if (producerMatches(request, writebackProd.writeEnable, writebackProd.dest))
        return forwardPkg::srcWriteback;
    return forwardPkg::srcNone;
endfunction

// forwarded word or the fallback when nothing matches
function automatic pipeTypesPkg::wordT newestValue(
    pipeTypesPkg::regIndexT request, pipeTypesPkg::wordT fallback, bit useExecute,
    pipeTypesPkg::producerT executeProd, pipeTypesPkg::loadProducerT exeMemProd,
    pipeTypesPkg::producerT memWbProd, pipeTypesPkg::producerT writebackProd);
    forwardPkg::forwardSourceE source;
    source = newestSource(request, useExecute, executeProd, exeMemProd, memWbProd,
                          writebackProd);
    case (source)
        forwardPkg::srcExecute:   return executeProd.value;
        forwardPkg::srcExeMem:    return exeMemProd.isLoad ? exeMemProd.loadData
                                                           : exeMemProd.value;
        forwardPkg::srcMemWb:     return memWbProd.value;
        forwardPkg::srcWriteback: return writebackProd.value;
        default:                  return fallback;
    endcase
endfunction

`default_nettype wire
`endif

/* dv/forwardUnitTb.sv */
`timescale 1ns/1ps
`include "forwardModel.svh"
`default_nettype none

module forwardUnitTb;

    localparam int clockPeriod    = 10;
    localparam int aluCycles      = 300;
    localparam int overrideCycles = 50;
    localparam int branchCycles   = 200;
    localparam int jumpCycles     = 200;
    localparam int directedCycles = 10;
    localparam int marginCycles   = 100;
    localparam int totalCycles    = 4 + aluCycles + overrideCycles + branchCycles
                                    + jumpCycles + directedCycles;

    // registered DUT outputs as the model expects them
    typedef struct packed {
        pipeTypesPkg::wordT forwardA;
        pipeTypesPkg::wordT forwardB;
        logic               aluForwarded;
        pipeTypesPkg::wordT branchOutA;
        pipeTypesPkg::wordT branchOutB;
        logic               branchForwarded;
        pipeTypesPkg::wordT jumpTarget;
        logic               jumpForwarded;
    } outputsT;

    logic                       CLOCK;
    logic                       RESET;
    pipeTypesPkg::regIndexT     regS;
    pipeTypesPkg::regIndexT     regT;
    pipeTypesPkg::wordT         operandA;
    pipeTypesPkg::wordT         operandB;
    logic                       immediate;
    logic                       jumpLink;
    logic                       branchRequest;
    pipeTypesPkg::regIndexT     branchRegS;
    pipeTypesPkg::regIndexT     branchRegT;
    pipeTypesPkg::wordT         branchA;
    pipeTypesPkg::wordT         branchB;
    logic                       jumpRequest;
    pipeTypesPkg::regIndexT     jumpReg;
    pipeTypesPkg::wordT         jumpValue;
    pipeTypesPkg::producerT     executeProd;
    pipeTypesPkg::loadProducerT exeMemProd;
    pipeTypesPkg::producerT     memWbProd;
    pipeTypesPkg::producerT     writebackProd;
    pipeTypesPkg::wordT         forwardA;
    pipeTypesPkg::wordT         forwardB;
    logic                       aluForwarded;
    pipeTypesPkg::wordT         branchOutA;
    pipeTypesPkg::wordT         branchOutB;
    logic                       branchForwarded;
    pipeTypesPkg::wordT         jumpTarget;
    logic                       jumpForwarded;

    outputsT     expected;
    logic [15:0] lfsrState;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          testStart;

    forwardUnit dut_i (.*);

    initial begin
        CLOCK = 1'b0;
        forever #(clockPeriod / 2) CLOCK = ~CLOCK;
    end

    initial begin
        #((totalCycles + marginCycles) * clockPeriod);
        $display("timeout: tests did not finish within %0d cycles", totalCycles + marginCycles);
        $display("Errors found");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextBit();
        logic feedback;
        feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], nextBit()};
        end
        return bits;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expectedValue,
                              input logic [31:0] actualValue);
        checkCount++;
        if (actualValue !== expectedValue) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name,
                     expectedValue, actualValue);
            errorCount++;
        end
    endtask

    task automatic compareOutputs();
        checkValue("forwardA", expected.forwardA, forwardA);
        checkValue("forwardB", expected.forwardB, forwardB);
        checkValue("aluForwarded", 32'(expected.aluForwarded), 32'(aluForwarded));
        checkValue("branchOutA", expected.branchOutA, branchOutA);
        checkValue("branchOutB", expected.branchOutB, branchOutB);
        checkValue("branchForwarded", 32'(expected.branchForwarded), 32'(branchForwarded));
        checkValue("jumpTarget", expected.jumpTarget, jumpTarget);
        checkValue("jumpForwarded", 32'(expected.jumpForwarded), 32'(jumpForwarded));
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %s done, %0d mismatches", name, errorCount - testStart);
        testStart = errorCount;
    endtask

    task automatic randomProducer(output pipeTypesPkg::producerT prod);
        prod.writeEnable = nextBit();
        prod.dest        = pipeTypesPkg::regIndexT'(takeBits(2));  // r0..r3 for frequent hits
        prod.value       = takeBits(32);
    endtask

    task automatic randomInputs();
        regS       = pipeTypesPkg::regIndexT'(takeBits(2));
        regT       = pipeTypesPkg::regIndexT'(takeBits(2));
        operandA   = takeBits(32);
        operandB   = takeBits(32);
        branchRegS = pipeTypesPkg::regIndexT'(takeBits(2));
        branchRegT = pipeTypesPkg::regIndexT'(takeBits(2));
        branchA    = takeBits(32);
        branchB    = takeBits(32);
        jumpReg    = pipeTypesPkg::regIndexT'(takeBits(2));
        jumpValue  = takeBits(32);
        randomProducer(executeProd);
        randomProducer(memWbProd);
        randomProducer(writebackProd);
        exeMemProd.writeEnable = nextBit();
        exeMemProd.dest        = pipeTypesPkg::regIndexT'(takeBits(2));
        exeMemProd.value       = takeBits(32);
        exeMemProd.isLoad      = nextBit();
        exeMemProd.loadData    = takeBits(32);
    endtask

    task automatic clearProducers();
        executeProd   = '0;
        exeMemProd    = '0;
        memWbProd     = '0;
        writebackProd = '0;
    endtask

    // what the DUT captures at the coming edge
    task automatic predict();
        forwardPkg::forwardSourceE sourceA;
        forwardPkg::forwardSourceE sourceB;
        forwardPkg::forwardSourceE sourceBranchA;
        forwardPkg::forwardSourceE sourceBranchB;
        forwardPkg::forwardSourceE sourceJump;
        sourceA = newestSource(regS, 1'b0, executeProd, exeMemProd, memWbProd, writebackProd);
        sourceB = newestSource(regT, 1'b0, executeProd, exeMemProd, memWbProd, writebackProd);
        sourceBranchA = newestSource(branchRegS, 1'b1, executeProd, exeMemProd, memWbProd,
                                     writebackProd);
        sourceBranchB = newestSource(branchRegT, 1'b1, executeProd, exeMemProd, memWbProd,
                                     writebackProd);
        sourceJump = newestSource(jumpReg, 1'b1, executeProd, exeMemProd, memWbProd,
                                  writebackProd);
        expected.forwardA = jumpLink ? operandA : newestValue(regS, operandA, 1'b0,
                            executeProd, exeMemProd, memWbProd, writebackProd);
        expected.forwardB = immediate ? operandB : newestValue(regT, operandB, 1'b0,
                            executeProd, exeMemProd, memWbProd, writebackProd);
        expected.aluForwarded = (!jumpLink && (sourceA != forwardPkg::srcNone))
                                || (!immediate && (sourceB != forwardPkg::srcNone));
        if (branchRequest) begin  // branch operands hold otherwise
            expected.branchOutA = newestValue(branchRegS, branchA, 1'b1, executeProd,
                                              exeMemProd, memWbProd, writebackProd);
            expected.branchOutB = newestValue(branchRegT, branchB, 1'b1, executeProd,
                                              exeMemProd, memWbProd, writebackProd);
        end
        expected.branchForwarded = branchRequest && ((sourceBranchA != forwardPkg::srcNone)
                                   || (sourceBranchB != forwardPkg::srcNone));
        if (jumpRequest) begin
            expected.jumpTarget = newestValue(jumpReg, jumpValue, 1'b1, executeProd,
                                              exeMemProd, memWbProd, writebackProd);
        end
        expected.jumpForwarded = jumpRequest && (sourceJump != forwardPkg::srcNone);
    endtask

    // inputs already driven so check one edge later
    task automatic runCycle();
        predict();
        @(posedge CLOCK);
        #1;
        compareOutputs();
    endtask

    initial begin
        lfsrState  = 16'd67;
        errorCount = 0;
        checkCount = 0;
        testCount  = 0;
        testStart  = 0;
        expected   = '0;
        RESET      = 1'b0;
        regS       = '0;
        regT       = '0;
        operandA   = '0;
        operandB   = '0;
        immediate  = 1'b0;
        jumpLink   = 1'b0;
        branchRequest = 1'b0;
        branchRegS = '0;
        branchRegT = '0;
        branchA    = '0;
        branchB    = '0;
        jumpRequest = 1'b0;
        jumpReg    = '0;
        jumpValue  = '0;
        clearProducers();
        repeat (4) @(posedge CLOCK);
        #1;
        RESET = 1'b1;

        compareOutputs();  // all zero out of reset
        finishTest("reset");

        repeat (aluCycles) begin
            randomInputs();
            runCycle();
        end
        clearProducers();
        regS = forwardPkg::zeroReg;
        regT = 5'd2;
        exeMemProd = '{1'b1, forwardPkg::zeroReg, 32'hdead_0000, 1'b0, 32'h0};
        memWbProd = '{1'b1, 5'd2, 32'h0000_2222};
        writebackProd = '{1'b1, 5'd2, 32'h0000_3333};  // older than MEM/WB so it loses
        runCycle();
        checkValue("forwardA", operandA, forwardA);
        checkValue("forwardB", 32'h0000_2222, forwardB);
        finishTest("aluRandom");

        repeat (overrideCycles) begin
            randomInputs();
            immediate = nextBit();
            jumpLink  = nextBit();
            runCycle();
        end
        clearProducers();
        regS = 5'd1;
        regT = 5'd1;
        immediate = 1'b1;
        jumpLink  = 1'b1;
        memWbProd = '{1'b1, 5'd1, 32'h1111_0000};
        runCycle();
        checkValue("forwardA", operandA, forwardA);
        checkValue("forwardB", operandB, forwardB);
        checkValue("aluForwarded", 32'd0, 32'(aluForwarded));
        finishTest("aluOverride");

        repeat (branchCycles) begin
            randomInputs();
            immediate     = nextBit();
            jumpLink      = nextBit();
            branchRequest = nextBit();
            runCycle();
        end
        clearProducers();
        branchRegS    = 5'd3;
        branchRegT    = forwardPkg::zeroReg;
        branchRequest = 1'b1;
        executeProd   = '{1'b1, 5'd3, 32'h0e0e_0e0e};
        exeMemProd    = '{1'b1, 5'd3, 32'h0f0f_0f0f, 1'b0, 32'h0};
        runCycle();
        checkValue("branchOutA", 32'h0e0e_0e0e, branchOutA);
        checkValue("branchForwarded", 32'd1, 32'(branchForwarded));
        branchRequest = 1'b0;
        runCycle();
        checkValue("branchForwarded", 32'd0, 32'(branchForwarded));  // one cycle only
        finishTest("branch");

        repeat (jumpCycles) begin
            randomInputs();
            branchRequest = nextBit();
            jumpRequest   = nextBit();
            runCycle();
        end
        clearProducers();
        jumpReg     = forwardPkg::linkReg;
        jumpRequest = 1'b1;
        exeMemProd  = '{1'b1, forwardPkg::linkReg, 32'h5555_aaaa, 1'b1, 32'h1234_5678};
        runCycle();
        checkValue("jumpTarget", 32'h1234_5678, jumpTarget);
        repeat (3) begin  // no request so target holds
            randomInputs();
            jumpRequest = 1'b0;
            runCycle();
            checkValue("jumpTarget", 32'h1234_5678, jumpTarget);
        end
        finishTest("jump");

        $display("%0d tests, %0d checks, %0d mismatches", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/forwardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
    input  logic                       CLOCK,
    input  logic                       RESET,
    // execute-stage operands
    input  pipeTypesPkg::regIndexT     regS,
    input  pipeTypesPkg::regIndexT     regT,
    input  pipeTypesPkg::wordT         operandA,
    input  pipeTypesPkg::wordT         operandB,
    input  logic                       immediate,
    input  logic                       jumpLink,
    // decode-stage branch and jump
    input  logic                       branchRequest,
    input  pipeTypesPkg::regIndexT     branchRegS,
    input  pipeTypesPkg::regIndexT     branchRegT,
    input  pipeTypesPkg::wordT         branchA,
    input  pipeTypesPkg::wordT         branchB,
    input  logic                       jumpRequest,
    input  pipeTypesPkg::regIndexT     jumpReg,
    input  pipeTypesPkg::wordT         jumpValue,
    // producers, youngest first
    input  pipeTypesPkg::producerT     executeProd,
    input  pipeTypesPkg::loadProducerT exeMemProd,
    input  pipeTypesPkg::producerT     memWbProd,
    input  pipeTypesPkg::producerT     writebackProd,
    output pipeTypesPkg::wordT         forwardA,
    output pipeTypesPkg::wordT         forwardB,
    output logic                       aluForwarded,
    output pipeTypesPkg::wordT         branchOutA,
    output pipeTypesPkg::wordT         branchOutB,
    output logic                       branchForwarded,
    output pipeTypesPkg::wordT         jumpTarget,
    output logic                       jumpForwarded
);

    aluOperandForward alu_i (
        .CLOCK        (CLOCK),
        .RESET        (RESET),
        .regS         (regS),
        .regT         (regT),
        .operandA     (operandA),
        .operandB     (operandB),
        .immediate    (immediate),
        .jumpLink     (jumpLink),
        .exeMemProd   (exeMemProd),
        .memWbProd    (memWbProd),
        .writebackProd(writebackProd),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .aluForwarded (aluForwarded)
    );

    controlTransferForward control_i (
        .CLOCK          (CLOCK),
        .RESET          (RESET),
        .branchRequest  (branchRequest),
        .branchRegS     (branchRegS),
        .branchRegT     (branchRegT),
        .branchA        (branchA),
        .branchB        (branchB),
        .jumpRequest    (jumpRequest),
        .jumpReg        (jumpReg),
        .jumpValue      (jumpValue),
        .executeProd    (executeProd),
        .exeMemProd     (exeMemProd),
        .memWbProd      (memWbProd),
        .writebackProd  (writebackProd),
        .branchOutA     (branchOutA),
        .branchOutB     (branchOutB),
        .branchForwarded(branchForwarded),
        .jumpTarget     (jumpTarget),
        .jumpForwarded  (jumpForwarded)
    );

endmodule

`default_nettype wire

/* verilog/controlTransferForward.sv */
`timescale 1ns/1ps
`default_nettype none

// forwarding for the decode-stage branch compare and jump-register target
module controlTransferForward (
    input  logic                       CLOCK,
    input  logic                       RESET,
    input  logic                       branchRequest,
    input  pipeTypesPkg::regIndexT     branchRegS,
    input  pipeTypesPkg::regIndexT     branchRegT,
    input  pipeTypesPkg::wordT         branchA,
    input  pipeTypesPkg::wordT         branchB,
    input  logic                       jumpRequest,
    input  pipeTypesPkg::regIndexT     jumpReg,
    input  pipeTypesPkg::wordT         jumpValue,
    input  pipeTypesPkg::producerT     executeProd,
    input  pipeTypesPkg::loadProducerT exeMemProd,
    input  pipeTypesPkg::producerT     memWbProd,
    input  pipeTypesPkg::producerT     writebackProd,
    output pipeTypesPkg::wordT         branchOutA,
    output pipeTypesPkg::wordT         branchOutB,
    output logic                       branchForwarded,
    output pipeTypesPkg::wordT         jumpTarget,
    output logic                       jumpForwarded
);

    pipeTypesPkg::wordT        selectA;
    pipeTypesPkg::wordT        selectB;
    pipeTypesPkg::wordT        selectJump;
    forwardPkg::forwardSourceE sourceA;
    forwardPkg::forwardSourceE sourceB;
    forwardPkg::forwardSourceE sourceJump;

    producerSelect #(
        .UseExecute(1'b1)
    ) branchSelectA_i (
        .request      (branchRegS),
        .fallback     (branchA),
        .executeProd  (executeProd),
        .exeMemProd   (exeMemProd),
        .memWbProd    (memWbProd),
        .writebackProd(writebackProd),
        .value        (selectA),
        .source       (sourceA)
    );

    producerSelect #(
        .UseExecute(1'b1)
    ) branchSelectB_i (
        .request      (branchRegT),
        .fallback     (branchB),
        .executeProd  (executeProd),
        .exeMemProd   (exeMemProd),
        .memWbProd    (memWbProd),
        .writebackProd(writebackProd),
        .value        (selectB),
        .source       (sourceB)
    );

    producerSelect #(
        .UseExecute(1'b1)
    ) jumpSelect_i (
        .request      (jumpReg),
        .fallback     (jumpValue),
        .executeProd  (executeProd),
        .exeMemProd   (exeMemProd),
        .memWbProd    (memWbProd),
        .writebackProd(writebackProd),
        .value        (selectJump),
        .source       (sourceJump)
    );

    always_ff @(posedge CLOCK) begin
        if (!RESET) begin
            branchOutA      <= '0;
            branchOutB      <= '0;
            branchForwarded <= 1'b0;
            jumpTarget      <= '0;
            jumpForwarded   <= 1'b0;
        end else begin
            if (branchRequest) begin  // operands hold between branches
                branchOutA <= selectA;
                branchOutB <= selectB;
            end
            if (jumpRequest) begin
                jumpTarget <= selectJump;
            end
            // flags fall again one cycle after the strobe
            branchForwarded <= branchRequest && ((sourceA != forwardPkg::srcNone)
                                                 || (sourceB != forwardPkg::srcNone));
            jumpForwarded   <= jumpRequest && (sourceJump != forwardPkg::srcNone);
        end
    end

endmodule

`default_nettype wire

/* verilog/aluOperandForward.sv */
`timescale 1ns/1ps
`default_nettype none

module aluOperandForward (
    input  logic                       CLOCK,
    input  logic                       RESET,
    input  pipeTypesPkg::regIndexT     regS,
    input  pipeTypesPkg::regIndexT     regT,
    input  pipeTypesPkg::wordT         operandA,
    input  pipeTypesPkg::wordT         operandB,
    input  logic                       immediate,  // operand B is an immediate
    input  logic                       jumpLink,   // operand A is the link address
    input  pipeTypesPkg::loadProducerT exeMemProd,
    input  pipeTypesPkg::producerT     memWbProd,
    input  pipeTypesPkg::producerT     writebackProd,
    output pipeTypesPkg::wordT         forwardA,
    output pipeTypesPkg::wordT         forwardB,
    output logic                       aluForwarded
);

    pipeTypesPkg::wordT        selectA;
    pipeTypesPkg::wordT        selectB;
    forwardPkg::forwardSourceE sourceA;
    forwardPkg::forwardSourceE sourceB;
    logic                      takeA;
    logic                      takeB;

    // the instruction in execute cannot use its own ALU result
    producerSelect #(
        .UseExecute(1'b0)
    ) selectA_i (
        .request      (regS),
        .fallback     (operandA),
        .executeProd  (pipeTypesPkg::idleProducer),
        .exeMemProd   (exeMemProd),
        .memWbProd    (memWbProd),
        .writebackProd(writebackProd),
        .value        (selectA),
        .source       (sourceA)
    );

    producerSelect #(
        .UseExecute(1'b0)
    ) selectB_i (
        .request      (regT),
        .fallback     (operandB),
        .executeProd  (pipeTypesPkg::idleProducer),
        .exeMemProd   (exeMemProd),
        .memWbProd    (memWbProd),
        .writebackProd(writebackProd),
        .value        (selectB),
        .source       (sourceB)
    );

    // an operand only counts as forwarded when its override is off
    assign takeA = !jumpLink && (sourceA != forwardPkg::srcNone);
    assign takeB = !immediate && (sourceB != forwardPkg::srcNone);

    always_ff @(posedge CLOCK) begin
        if (!RESET) begin
            forwardA     <= '0;
            forwardB     <= '0;
            aluForwarded <= 1'b0;
        end else begin
            forwardA     <= takeA ? selectA : operandA;
            forwardB     <= takeB ? selectB : operandB;  // immediate stays put
            aluForwarded <= takeA || takeB;
        end
    end

endmodule

`default_nettype wire

/* verilog/producerSelect.sv */
`timescale 1ns/1ps
`default_nettype none

// newest value for one register out of the in-flight producers
module producerSelect #(
    parameter bit UseExecute = 1'b1  // 0 when the requester sits in execute itself
) (
    input  pipeTypesPkg::regIndexT     request,
    input  pipeTypesPkg::wordT         fallback,
    input  pipeTypesPkg::producerT     executeProd,
    input  pipeTypesPkg::loadProducerT exeMemProd,
    input  pipeTypesPkg::producerT     memWbProd,
    input  pipeTypesPkg::producerT     writebackProd,
    output pipeTypesPkg::wordT         value,
    output forwardPkg::forwardSourceE  source
);

    logic               requestLive;
    logic               executeHit;
    logic               exeMemHit;
    logic               memWbHit;
    logic               writebackHit;
    pipeTypesPkg::wordT exeMemValue;

    assign requestLive = (request != forwardPkg::zeroReg);  // r0 reads as itself

    assign executeHit = UseExecute && requestLive && executeProd.writeEnable
                        && (executeProd.dest == request);
    assign exeMemHit = requestLive && exeMemProd.writeEnable
                       && (exeMemProd.dest == request);
    assign memWbHit = requestLive && memWbProd.writeEnable
                      && (memWbProd.dest == request);
    assign writebackHit = requestLive && writebackProd.writeEnable
                          && (writebackProd.dest == request);

    // a load in EXE/MEM hands over the memory data
    assign exeMemValue = exeMemProd.isLoad ? exeMemProd.loadData : exeMemProd.value;

    // youngest producer wins
    always_comb begin
        value  = fallback;
        source = forwardPkg::srcNone;
        if (executeHit) begin
            value  = executeProd.value;
            source = forwardPkg::srcExecute;
        end else if (exeMemHit) begin
            value  = exeMemValue;
            source = forwardPkg::srcExeMem;
        end else if (memWbHit) begin
            value  = memWbProd.value;
            source = forwardPkg::srcMemWb;
        end else if (writebackHit) begin
            value  = writebackProd.value;  // same-cycle register file write
            source = forwardPkg::srcWriteback;
        end
    end

endmodule

`default_nettype wire

/* verilog/forwardPkg.sv */
`default_nettype none

package forwardPkg;

    // which producer a forwarded value came from
    typedef enum logic [2:0] {
        srcNone      = 3'd0,  // fallback value kept
        srcExecute   = 3'd1,  // ALU result of the instruction in execute
        srcExeMem    = 3'd2,
        srcMemWb     = 3'd3,
        srcWriteback = 3'd4   // register file write port
    } forwardSourceE;

    // hardwired zero, never a forwarding target
    localparam pipeTypesPkg::regIndexT zeroReg = 5'd0;

    localparam pipeTypesPkg::regIndexT linkReg = 5'd31;  // jump-and-link destination

endpackage

`default_nettype wire

/* verilog/pipeTypesPkg.sv */
`default_nettype none

package pipeTypesPkg;

    localparam int wordWidth     = 32;
    localparam int regIndexWidth = 5;

    typedef logic [wordWidth-1:0]     wordT;      // one datapath word
    typedef logic [regIndexWidth-1:0] regIndexT;  // architectural register number

    // one pipeline latch that may write a register
    typedef struct packed {
        logic     writeEnable;  // latch will write dest
        regIndexT dest;
        wordT     value;        // result headed for dest
    } producerT;

    // EXE/MEM latch, which may still be waiting on its load
    typedef struct packed {
        logic     writeEnable;
        regIndexT dest;
        wordT     value;        // ALU result carried down the pipe
        logic     isLoad;       // dest gets loadData, not value
        wordT     loadData;     // data coming back from memory
    } loadProducerT;

    // producer that never matches, for paths without an execute source
    localparam producerT idleProducer = '0;

endpackage

`default_nettype wire
